// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tbCpu
FILELIST = tb.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = all tests passed

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/cpuCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCore #(
    parameter cpuPkg::word resetPc = '0,
    parameter int regCount = 32
) (
    input  wire               clk,
    input  wire               rstN,
    output cpuPkg::word       InstAddress,
    input  wire cpuPkg::word  InstInput,
    output cpuPkg::word       MemAddress,
    input  wire cpuPkg::word  MemReadData,
    output cpuPkg::word       MemWriteData,
    output logic              MemReadEN,
    output logic              MemWriteEN
);
    import cpuPkg::*;

    // Fetch to decode
    word    instr;
    logic   stall;

    // Decode to execute
    aluOp   aluOpEx;
    logic   useImmEx;
    word    operandAEx;
    word    operandBEx;
    word    immEx;
    regAddr srcAEx;
    regAddr srcBEx;
    regAddr destRegEx;
    logic   regWriteEx;
    logic   memReadEx;
    logic   memWriteEx;

    // Execute to write-back
    regAddr memDestOut;
    logic   memLoad;

    forwardIf fwdBus ();

    // Sequential PC output has no consumer without branches
    fetchStage #(.resetPc(resetPc)) fetch (
        .clk(clk), .rstN(rstN), .stall(stall),
        .instAddress(InstAddress), .instIn(InstInput),
        .instr(instr), .pcNext()
    );

    decodeStage #(.regCount(regCount)) decode (
        .clk(clk), .rstN(rstN), .instr(instr), .fwd(fwdBus.regFile), .stall(stall),
        .aluOpEx(aluOpEx), .useImmEx(useImmEx),
        .operandAEx(operandAEx), .operandBEx(operandBEx), .immEx(immEx),
        .srcAEx(srcAEx), .srcBEx(srcBEx), .destRegEx(destRegEx),
        .regWriteEx(regWriteEx), .memReadEx(memReadEx), .memWriteEx(memWriteEx)
    );

    executeStage execute (
        .clk(clk), .rstN(rstN),
        .aluOpEx(aluOpEx), .useImmEx(useImmEx),
        .operandAEx(operandAEx), .operandBEx(operandBEx), .immEx(immEx),
        .srcAEx(srcAEx), .srcBEx(srcBEx), .destRegEx(destRegEx),
        .regWriteEx(regWriteEx), .memReadEx(memReadEx), .memWriteEx(memWriteEx),
        .fwd(fwdBus.memSide),
        .memAddress(MemAddress), .memWriteData(MemWriteData),
        .memReadEn(MemReadEN), .memWriteEn(MemWriteEN),
        .memDestOut(memDestOut), .memLoad(memLoad)
    );

    memWbStage writeBack (
        .clk(clk), .rstN(rstN),
        .memDest(memDestOut), .memLoad(memLoad),
        .memResult(fwdBus.memResult), .memWrite(fwdBus.memWrite),
        .memReadData(MemReadData), .fwd(fwdBus.wbSide)
    );

endmodule

`default_nettype wire

// ==== logic/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0] word;
    typedef logic [regAddrWidth-1:0] regAddr;

    // Instruction field positions
    localparam int opHi = 31;
    localparam int opLo = 26;
    localparam int rsHi = 25;
    localparam int rsLo = 21;
    localparam int rtHi = 20;
    localparam int rtLo = 16;
    localparam int rdHi = 15;
    localparam int rdLo = 11;
    localparam int fnHi = 5;
    localparam int fnLo = 0;
    localparam int immHi = 15;
    localparam int immLo = 0;

    // Opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;

    // SPECIAL function codes
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOp;

endpackage

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeStage #(
    parameter int regCount = 32
) (
    input  wire                clk,
    input  wire                rstN,
    input  wire cpuPkg::word   instr,
    forwardIf.regFile          fwd,
    output logic               stall,
    output cpuPkg::aluOp       aluOpEx,
    output logic               useImmEx,
    output cpuPkg::word        operandAEx,
    output cpuPkg::word        operandBEx,
    output cpuPkg::word        immEx,
    output cpuPkg::regAddr     srcAEx,
    output cpuPkg::regAddr     srcBEx,
    output cpuPkg::regAddr     destRegEx,
    output logic               regWriteEx,
    output logic               memReadEx,
    output logic               memWriteEx
);
    import cpuPkg::*;

    localparam int idxWidth = $clog2(regCount);

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr     rs;
    regAddr     rt;
    regAddr     rd;
    word        imm;
    aluOp       aluSel;
    logic       useImm;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       usesA;
    logic       usesB;
    regAddr     destReg;
    word        regs [regCount];
    word        readA;
    word        readB;

    assign opcode = instr[opHi:opLo];
    assign funct = instr[fnHi:fnLo];
    assign rs = instr[rsHi:rsLo];
    assign rt = instr[rtHi:rtLo];
    assign rd = instr[rdHi:rdLo];
    assign imm = {{(dataWidth-16){instr[immHi]}}, instr[immHi:immLo]};

    //////////////////////////////////////////////////////////////////////
    // Control generation
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        aluSel = aluAdd;
        useImm = 1'b0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        usesA = 1'b0;
        usesB = 1'b0;
        destReg = rt;
        case (opcode)
            opSpecial: begin
                destReg = rd;
                regWrite = 1'b1;
                usesA = 1'b1;
                usesB = 1'b1;
                case (funct)
                    fnAddu: aluSel = aluAdd;
                    fnSubu: aluSel = aluSub;
                    fnAnd:  aluSel = aluAnd;
                    fnOr:   aluSel = aluOr;
                    fnXor:  aluSel = aluXor;
                    fnSlt:  aluSel = aluSlt;
                    // NOP and anything unsupported
                    default: begin
                        regWrite = 1'b0;
                        usesA = 1'b0;
                        usesB = 1'b0;
                    end
                endcase
            end
            opAddiu: begin
                useImm = 1'b1;
                regWrite = 1'b1;
                usesA = 1'b1;
            end
            opLw: begin
                useImm = 1'b1;
                regWrite = 1'b1;
                memRead = 1'b1;
                usesA = 1'b1;
            end
            opSw: begin
                useImm = 1'b1;
                memWrite = 1'b1;
                usesA = 1'b1;
                usesB = 1'b1;
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register file with write-back bypass
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fwd.wbWrite && fwd.wbDest != '0)
            regs[fwd.wbDest[idxWidth-1:0]] <= fwd.wbData;
    end

    assign readA = (rs == '0) ? '0 :
        (fwd.wbWrite && fwd.wbDest == rs) ? fwd.wbData : regs[rs[idxWidth-1:0]];
    assign readB = (rt == '0) ? '0 :
        (fwd.wbWrite && fwd.wbDest == rt) ? fwd.wbData : regs[rt[idxWidth-1:0]];

    // Load in execute feeding a source here
    assign stall = memReadEx && destRegEx != '0 &&
        ((usesA && destRegEx == rs) || (usesB && destRegEx == rt));

    // Decode-to-execute register, bubble on stall
    always_ff @(posedge clk) begin
        if (!rstN || stall) begin
            regWriteEx <= 1'b0;
            memReadEx <= 1'b0;
            memWriteEx <= 1'b0;
        end else begin
            regWriteEx <= regWrite;
            memReadEx <= memRead;
            memWriteEx <= memWrite;
        end
        aluOpEx <= aluSel;
        useImmEx <= useImm;
        operandAEx <= readA;
        operandBEx <= readB;
        immEx <= imm;
        srcAEx <= rs;
        srcBEx <= rt;
        destRegEx <= destReg;
    end

    // Fetch holds the stalled instruction for its second decode
    stallHoldsInstr: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(instr));

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeStage (
    input  wire                   clk,
    input  wire                   rstN,
    input  wire cpuPkg::aluOp     aluOpEx,
    input  wire                   useImmEx,
    input  wire cpuPkg::word      operandAEx,
    input  wire cpuPkg::word      operandBEx,
    input  wire cpuPkg::word      immEx,
    input  wire cpuPkg::regAddr   srcAEx,
    input  wire cpuPkg::regAddr   srcBEx,
    input  wire cpuPkg::regAddr   destRegEx,
    input  wire                   regWriteEx,
    input  wire                   memReadEx,
    input  wire                   memWriteEx,
    forwardIf.memSide             fwd,
    output cpuPkg::word           memAddress,
    output cpuPkg::word           memWriteData,
    output logic                  memReadEn,
    output logic                  memWriteEn,
    output cpuPkg::regAddr        memDestOut,
    output logic                  memLoad
);
    import cpuPkg::*;

    word    fwdA;
    word    fwdB;
    word    opB;
    word    aluOut;
    word    resultReg;
    word    storeData;
    regAddr destReg;
    logic   writeReg;
    logic   readReg;
    logic   storeReg;

    // Memory stage wins over write-back
    assign fwdA = (fwd.memWrite && fwd.memDest != '0 && fwd.memDest == srcAEx) ? fwd.memResult :
        (fwd.wbWrite && fwd.wbDest != '0 && fwd.wbDest == srcAEx) ? fwd.wbData : operandAEx;
    assign fwdB = (fwd.memWrite && fwd.memDest != '0 && fwd.memDest == srcBEx) ? fwd.memResult :
        (fwd.wbWrite && fwd.wbDest != '0 && fwd.wbDest == srcBEx) ? fwd.wbData : operandBEx;

    assign opB = useImmEx ? immEx : fwdB;

    always_comb begin
        case (aluOpEx)
            aluAdd:  aluOut = fwdA + opB;
            aluSub:  aluOut = fwdA - opB;
            aluAnd:  aluOut = fwdA & opB;
            aluOr:   aluOut = fwdA | opB;
            aluXor:  aluOut = fwdA ^ opB;
            aluSlt:  aluOut = {{(dataWidth-1){1'b0}}, $signed(fwdA) < $signed(opB)};
            default: aluOut = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Execute-to-memory register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            writeReg <= 1'b0;
            readReg <= 1'b0;
            storeReg <= 1'b0;
        end else begin
            writeReg <= regWriteEx;
            readReg <= memReadEx;
            storeReg <= memWriteEx;
        end
        resultReg <= aluOut;
        // Store data takes the forwarded rt
        storeData <= fwdB;
        destReg <= destRegEx;
    end

    assign fwd.memWrite = writeReg;
    assign fwd.memDest = destReg;
    assign fwd.memResult = resultReg;

    assign memAddress = resultReg;
    assign memWriteData = storeData;
    assign memReadEn = readReg;
    assign memWriteEn = storeReg;
    assign memDestOut = destReg;
    assign memLoad = readReg;

    memExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(memReadEn && memWriteEn));

endmodule

`default_nettype wire

// ==== logic/fetchStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchStage #(
    parameter cpuPkg::word resetPc = '0
) (
    input  wire               clk,
    input  wire               rstN,
    input  wire               stall,
    output cpuPkg::word       instAddress,
    input  wire cpuPkg::word  instIn,
    output cpuPkg::word       instr,
    output cpuPkg::word       pcNext
);
    import cpuPkg::*;

    word pc;

    assign instAddress = pc;
    assign pcNext = pc + word'(4);

    // PC and fetch-to-decode register, both frozen by a load-use stall
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
            instr <= '0;
        end else if (!stall) begin
            pc <= pcNext;
            instr <= instIn;
        end
    end

    // Only sequential fetch, so the PC never leaves word alignment
    pcAligned: assert property (@(posedge clk) disable iff (!rstN)
        instAddress[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== logic/forwardIf.sv ====
`timescale 1ns/100ps
`default_nettype none

// Result buses from the memory and write-back stages
interface forwardIf;
    import cpuPkg::*;

    // Instruction in the memory stage
    logic   memWrite;
    regAddr memDest;
    word    memResult;

    // Final write-back
    logic   wbWrite;
    regAddr wbDest;
    word    wbData;

    modport memSide (
        output memWrite, memDest, memResult,
        input  wbWrite, wbDest, wbData
    );

    modport wbSide (output wbWrite, wbDest, wbData);

    modport regFile (input wbWrite, wbDest, wbData);

endinterface

`default_nettype wire

// ==== logic/memWbStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memWbStage (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire cpuPkg::regAddr  memDest,
    input  wire                  memLoad,
    input  wire cpuPkg::word     memResult,
    input  wire                  memWrite,
    input  wire cpuPkg::word     memReadData,
    forwardIf.wbSide             fwd
);
    import cpuPkg::*;

    word    resultReg;
    word    loadData;
    regAddr destReg;
    logic   writeReg;
    logic   loadReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            writeReg <= 1'b0;
            loadReg <= 1'b0;
        end else begin
            writeReg <= memWrite;
            loadReg <= memLoad;
        end
        resultReg <= memResult;
        loadData <= memReadData;
        destReg <= memDest;
    end

    assign fwd.wbWrite = writeReg;
    assign fwd.wbDest = destReg;
    // Load data for LW, ALU result for everything else
    assign fwd.wbData = loadReg ? loadData : resultReg;

endmodule

`default_nettype wire

// ==== tb.f ====
logic/cpuPkg.sv
logic/forwardIf.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/cpuCore.sv
testbench/tbCpu.sv

// ==== testbench/tbCpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbCpu;
    import cpuPkg::*;

    localparam word resetPc = '0;
    localparam int imemDepth = 256;
    localparam int dmemDepth = 64;
    localparam int drainNops = 8;
    localparam int randLength = 200;
    localparam int timeoutMargin = 20;
    localparam logic [31:0] seed = 32'hda36_0c16;

    logic clk = 1'b0;
    logic rstN;
    word  instAddress;
    word  instInput;
    word  memAddress;
    word  memReadData;
    word  memWriteData;
    logic memReadEn;
    logic memWriteEn;

    word imem [imemDepth];
    word dmem [dmemDepth];
    word modelMem [dmemDepth];
    word modelRegs [8];
    word prog [$];
    word expAddr [$];
    word expData [$];
    word expLoad [$];
    logic [31:0] randState;
    int storeCount;
    int loadCount;
    int errors;
    int testsRun;
    int testsFailed;

    always #2 clk = ~clk;

    cpuCore #(.resetPc(resetPc), .regCount(32)) dut0 (
        .clk(clk), .rstN(rstN),
        .InstAddress(instAddress), .InstInput(instInput),
        .MemAddress(memAddress), .MemReadData(memReadData), .MemWriteData(memWriteData),
        .MemReadEN(memReadEn), .MemWriteEN(memWriteEn)
    );

    // Past the end of the array every fetch is a NOP
    assign instInput = (instAddress[31:2] < 30'(imemDepth)) ? imem[instAddress[9:2]] : '0;
    assign memReadData = dmem[memAddress[7:2]];

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding and random source
    //////////////////////////////////////////////////////////////////////

    function automatic word encodeR(input logic [5:0] fn, input int rd, input int rs,
                                    input int rt);
        return {opSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word encodeI(input logic [5:0] op, input int rt, input int rs,
                                    input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic int nextRand();
        randState = randState * 32'd1664525 + 32'd1013904223;
        return int'(randState[31:16]);
    endfunction

    function automatic logic [5:0] pickFunct(input int idx);
        case (idx)
            0: return fnAddu;
            1: return fnSubu;
            2: return fnAnd;
            3: return fnOr;
            4: return fnXor;
            default: return fnSlt;
        endcase
    endfunction

    // Half R-type, then ADDIU, LW and SW, all on registers 0 to 7
    function automatic word randomInstr();
        int kind;
        int rd;
        int rs;
        int rt;
        kind = nextRand() % 10;
        rd = nextRand() % 8;
        rs = nextRand() % 8;
        rt = nextRand() % 8;
        if (kind < 5)
            return encodeR(pickFunct(nextRand() % 6), rd, rs, rt);
        else if (kind < 7)
            return encodeI(opAddiu, rt, rs, nextRand());
        else if (kind == 7)
            return encodeI(opLw, rt, 0, (nextRand() % dmemDepth) * 4);
        return encodeI(opSw, rt, 0, (nextRand() % dmemDepth) * 4);
    endfunction

    function automatic word fillWord(input int idx);
        return word'(idx * 4) * 32'h9e37_79b1 + 32'h1357_2468;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    task setReg(input logic [4:0] r, input word value);
        if (r != 5'd0)
            modelRegs[r[2:0]] = value;
    endtask

    task runModel;
        word instr;
        word a;
        word b;
        word imm;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        foreach (modelRegs[i]) modelRegs[i] = '0;
        expAddr.delete();
        expData.delete();
        expLoad.delete();
        foreach (prog[i]) begin
            instr = prog[i];
            rs = instr[25:21];
            rt = instr[20:16];
            rd = instr[15:11];
            a = modelRegs[rs[2:0]];
            b = modelRegs[rt[2:0]];
            imm = {{16{instr[15]}}, instr[15:0]};
            case (instr[31:26])
                opSpecial: begin
                    case (instr[5:0])
                        fnAddu: setReg(rd, a + b);
                        fnSubu: setReg(rd, a - b);
                        fnAnd:  setReg(rd, a & b);
                        fnOr:   setReg(rd, a | b);
                        fnXor:  setReg(rd, a ^ b);
                        fnSlt:  setReg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                opAddiu: setReg(rt, a + imm);
                opLw: begin
                    setReg(rt, modelMem[(a + imm) >> 2]);
                    expLoad.push_back(a + imm);
                end
                opSw: begin
                    modelMem[(a + imm) >> 2] = b;
                    expAddr.push_back(a + imm);
                    expData.push_back(b);
                end
                default: ;
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequencing
    //////////////////////////////////////////////////////////////////////

    task compareWord(input string name, input word got, input word expected);
        if (got !== expected) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    task applyReset;
        rstN <= 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // Seed r1 to r7 with known values ahead of each program
    task startProgram;
        prog.delete();
        for (int r = 1; r < 8; r++)
            prog.push_back(encodeI(opAddiu, r, 0, r * 'h2f1d));
    endtask

    task runProgram(input string name, input logic quiet);
        int cycles;
        int limit;
        int startErrors;
        word endAddr;
        repeat (drainNops) prog.push_back('0);
        foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : '0;
        foreach (dmem[i]) begin
            dmem[i] <= fillWord(i);
            modelMem[i] = fillWord(i);
        end
        runModel();
        limit = 2 * prog.size() + timeoutMargin;
        endAddr = resetPc + word'(prog.size() * 4);
        startErrors = errors;
        storeCount = 0;
        loadCount = 0;
        applyReset();
        cycles = 0;
        while (instAddress != endAddr) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout in %s after %0d cycles", name, cycles);
                $display("tests failed");
                $finish;
            end
            if (cycles == 1)
                compareWord("InstAddress", instAddress, resetPc);
            if (quiet && storeCount == 0 && memReadEn) begin
                $display("Memory read enable went high before the first store");
                errors++;
            end
            if (memReadEn) begin
                if (loadCount >= expLoad.size()) begin
                    $display("Unexpected extra load from address 0x%08h", memAddress);
                    errors++;
                end else begin
                    compareWord("MemAddress", memAddress, expLoad[loadCount]);
                end
                loadCount++;
            end
            if (memWriteEn) begin
                dmem[memAddress[7:2]] <= memWriteData;
                if (storeCount >= expAddr.size()) begin
                    $display("Unexpected extra store to address 0x%08h", memAddress);
                    errors++;
                end else begin
                    compareWord("MemAddress", memAddress, expAddr[storeCount]);
                    compareWord("MemWriteData", memWriteData, expData[storeCount]);
                end
                storeCount++;
            end
        end
        if (storeCount < expAddr.size()) begin
            $display("Missing stores in %s: saw %0d of %0d", name, storeCount,
                     expAddr.size());
            errors++;
        end
        if (loadCount < expLoad.size()) begin
            $display("Missing loads in %s: saw %0d of %0d", name, loadCount,
                     expLoad.size());
            errors++;
        end
        testsRun++;
        if (errors == startErrors) begin
            $display("%s: pass, %0d stores in %0d cycles", name, storeCount, cycles);
        end else begin
            testsFailed++;
            $display("%s: FAIL, %0d errors", name, errors - startErrors);
        end
    endtask

    initial begin
        rstN <= 1'b0;
        randState = seed;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        foreach (imem[i]) imem[i] = '0;

        startProgram();
        prog.push_back(encodeI(opSw, 1, 0, 0));
        runProgram("reset", 1'b1);

        // Every ALU operation in both operand orders
        startProgram();
        prog.push_back(encodeI(opAddiu, 1, 0, 'h1234));
        prog.push_back(encodeI(opAddiu, 2, 0, -5));
        for (int k = 0; k < 6; k++) begin
            prog.push_back(encodeR(pickFunct(k), 3, 1, 2));
            prog.push_back(encodeI(opSw, 3, 0, k * 4));
            prog.push_back(encodeR(pickFunct(k), 4, 2, 1));
            prog.push_back(encodeI(opSw, 4, 0, (k + 8) * 4));
        end
        runProgram("aluOps", 1'b0);

        // Dependent chain through memory and write-back forwarding
        startProgram();
        prog.push_back(encodeI(opAddiu, 1, 0, 7));
        prog.push_back(encodeR(fnAddu, 2, 1, 1));
        prog.push_back(encodeR(fnAddu, 3, 2, 1));
        prog.push_back(encodeR(fnSubu, 4, 3, 2));
        prog.push_back(encodeI(opSw, 4, 0, 0));
        prog.push_back(encodeR(fnXor, 5, 4, 3));
        prog.push_back(encodeI(opSw, 5, 0, 4));
        prog.push_back(encodeR(fnOr, 6, 5, 1));
        prog.push_back('0);
        prog.push_back(encodeI(opSw, 6, 0, 8));
        runProgram("forwarding", 1'b0);

        startProgram();
        prog.push_back(encodeI(opLw, 1, 0, 16));
        prog.push_back(encodeR(fnAddu, 2, 1, 1));
        prog.push_back(encodeI(opSw, 2, 0, 0));
        prog.push_back(encodeI(opLw, 3, 0, 20));
        prog.push_back(encodeI(opSw, 3, 0, 4));
        prog.push_back(encodeI(opLw, 4, 0, 4));
        prog.push_back(encodeI(opAddiu, 5, 4, 1));
        prog.push_back(encodeI(opSw, 5, 0, 8));
        runProgram("loadUse", 1'b0);

        startProgram();
        prog.push_back(encodeI(opAddiu, 0, 0, 'h55));
        prog.push_back(encodeR(fnAddu, 0, 1, 1));
        prog.push_back(encodeI(opSw, 0, 0, 0));
        prog.push_back(encodeR(fnOr, 2, 0, 1));
        prog.push_back(encodeI(opSw, 2, 0, 4));
        prog.push_back(encodeI(opLw, 0, 0, 8));
        prog.push_back(encodeI(opSw, 0, 0, 12));
        runProgram("regZero", 1'b0);

        startProgram();
        repeat (randLength) prog.push_back(randomInstr());
        runProgram("random", 1'b0);

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
